//--- src/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int XLEN = 64;

    // access size as encoded by the load and store pipes
    typedef enum logic [1:0] {
        MEM_B = 2'd0,
        MEM_H = 2'd1,
        MEM_W = 2'd2,
        MEM_D = 2'd3
    } mem_size_t;

    typedef logic [XLEN-1:0] vaddr_t;
    typedef logic [XLEN/8-1:0] byte_mask_t;
    // address with the byte offset inside the doubleword removed
    typedef logic [XLEN-4:0] dword_addr_t;

    function automatic dword_addr_t dword_of(input vaddr_t addr);
        return addr[XLEN-1:3];
    endfunction

    // bytes past the doubleword end fall off the shift
    function automatic byte_mask_t byte_mask_of(input logic [2:0] offs, input mem_size_t size);
        byte_mask_t run;
        case (size)
            MEM_B:   run = 8'h01;
            MEM_H:   run = 8'h03;
            MEM_W:   run = 8'h0f;
            default: run = 8'hff;
        endcase
        return run << offs;
    endfunction

endpackage

`default_nettype wire

//--- src/lsq_pkg.sv
`default_nettype none

package lsq_pkg;

    localparam int LQ_DEPTH_MAX = 8;
    localparam int LQ_SLOT_W = $clog2(LQ_DEPTH_MAX);
    localparam int SQ_DEPTH = 16;
    localparam int SQ_SLOT_W = $clog2(SQ_DEPTH);
    localparam int ROB_IDX_W = 6;

    // queue indices carry a wrap flag above the slot number
    typedef struct packed {
        logic                 flag;
        logic [LQ_SLOT_W-1:0] slot;
    } lq_idx_t;

    typedef struct packed {
        logic                 flag;
        logic [SQ_SLOT_W-1:0] slot;
    } sq_idx_t;

    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    typedef struct packed {
        logic                 valid;
        logic                 addr_vld;
        // written back, may retire
        logic                 finished;
        rob_idx_t             rob_idx;
        // store queue tail seen at dispatch
        sq_idx_t              sq_idx;
        mem_pkg::dword_addr_t dw_addr;
        mem_pkg::byte_mask_t  mask;
    } lq_entry_t;

    // load pipe, issue stage
    typedef struct packed {
        logic               vld;
        lq_idx_t            lq_idx;
        mem_pkg::vaddr_t    vaddr;
        mem_pkg::mem_size_t size;
    } ld_issue_t;

    typedef struct packed {
        logic    vld;
        lq_idx_t lq_idx;
    } ld_wb_t;

    // store address pipe
    typedef struct packed {
        logic               vld;
        sq_idx_t            sq_idx;
        mem_pkg::vaddr_t    vaddr;
        mem_pkg::mem_size_t size;
    } st_addr_t;

    // true when a is older than b in store queue order
    function automatic logic sq_before(input sq_idx_t a, input sq_idx_t b);
        if (a.flag == b.flag) begin
            return a.slot < b.slot;
        end
        return a.slot > b.slot;
    endfunction

endpackage

`default_nettype wire

//--- src/popcount.sv
`timescale 1ns/1ps
`default_nettype none

module popcount #(
    parameter int WIDTH = 2
) (
    input  wire  [WIDTH-1:0]           i_bits,
    output logic [$clog2(WIDTH+1)-1:0] o_count
);

    localparam int CW = $clog2(WIDTH + 1);

    always_comb begin
        o_count = '0;
        for (int i = 0; i < WIDTH; i++) begin
            o_count = o_count + CW'(i_bits[i]);
        end
    end

endmodule

`default_nettype wire

//--- src/lq_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module lq_alloc #(
    parameter int DEPTH   = 8,
    parameter int ENQ_NUM = 2,
    parameter int DEQ_NUM = 2
) (
    input  wire                                           clk,
    input  wire                                           i_rst_n,
    input  wire                                           i_flush,
    input  wire                                           i_enq_vld,
    input  wire  [ENQ_NUM-1:0]                            i_enq_req,
    input  wire  [$clog2(DEQ_NUM+1)-1:0]                  i_commit_num,
    output logic                                          o_can_enq,
    output lsq_pkg::lq_idx_t [ENQ_NUM-1:0]                o_alloc_idx,
    output logic [ENQ_NUM-1:0]                            o_wr_en,
    output logic [ENQ_NUM-1:0][lsq_pkg::LQ_SLOT_W-1:0]    o_wr_slot,
    output lsq_pkg::lq_idx_t                              o_head
);

    localparam int AW = $clog2(DEPTH);
    localparam int PW = AW + 1;
    localparam int SW = lsq_pkg::LQ_SLOT_W;
    localparam int CW = $clog2(ENQ_NUM + 1);

    // msb of each pointer is the wrap flag
    logic [PW-1:0] tail_ptr;
    logic [PW-1:0] head_ptr;
    logic [PW-1:0] count;
    logic [CW-1:0] req_cnt;
    logic [CW-1:0] acc_cnt;
    logic [ENQ_NUM-1:0] acc;
    logic [ENQ_NUM-1:0][PW-1:0] alloc_ptr;

    popcount #(.WIDTH(ENQ_NUM)) u_req_cnt (.i_bits(i_enq_req), .o_count(req_cnt));
    popcount #(.WIDTH(ENQ_NUM)) u_acc_cnt (.i_bits(acc), .o_count(acc_cnt));

    // whole group or nothing
    assign o_can_enq = PW'(req_cnt) <= (PW'(DEPTH) - count);
    assign acc = (i_enq_vld && o_can_enq) ? i_enq_req : '0;
    assign o_wr_en = acc;

    // set bits take consecutive slots in port order
    always_comb begin
        logic [PW-1:0] off;
        off = '0;
        for (int k = 0; k < ENQ_NUM; k++) begin
            alloc_ptr[k] = tail_ptr + off;
            o_alloc_idx[k].flag = alloc_ptr[k][AW];
            o_alloc_idx[k].slot = SW'(alloc_ptr[k][AW-1:0]);
            o_wr_slot[k] = SW'(alloc_ptr[k][AW-1:0]);
            off = off + PW'(i_enq_req[k]);
        end
    end

    assign o_head.flag = head_ptr[AW];
    assign o_head.slot = SW'(head_ptr[AW-1:0]);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tail_ptr <= '0;
            head_ptr <= '0;
            count    <= '0;
        end else if (i_flush) begin
            tail_ptr <= '0;
            head_ptr <= '0;
            count    <= '0;
        end else begin
            tail_ptr <= tail_ptr + PW'(acc_cnt);
            head_ptr <= head_ptr + PW'(i_commit_num);
            count    <= count + PW'(acc_cnt) - PW'(i_commit_num);
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (!i_rst_n)
        count <= PW'(DEPTH))
        else $error("load queue occupancy above depth");

    a_commit_le_count: assert property (@(posedge clk) disable iff (!i_rst_n)
        !i_flush |-> PW'(i_commit_num) <= count)
        else $error("commit of more loads than are queued");

endmodule

`default_nettype wire

//--- src/lq_entries.sv
`timescale 1ns/1ps
`default_nettype none

module lq_entries #(
    parameter int DEPTH   = 8,
    parameter int ENQ_NUM = 2,
    parameter int DEQ_NUM = 2
) (
    input  wire                                          clk,
    input  wire                                          i_rst_n,
    input  wire                                          i_flush,
    input  wire  [ENQ_NUM-1:0]                           i_wr_en,
    input  wire  [ENQ_NUM-1:0][lsq_pkg::LQ_SLOT_W-1:0]   i_wr_slot,
    input  wire  lsq_pkg::rob_idx_t [ENQ_NUM-1:0]        i_enq_rob_idx,
    input  wire  lsq_pkg::sq_idx_t [ENQ_NUM-1:0]         i_enq_sq_idx,
    input  wire  lsq_pkg::ld_issue_t                     i_ld_issue,
    input  wire  lsq_pkg::ld_wb_t                        i_ld_wb,
    input  wire  lsq_pkg::st_addr_t                      i_st_addr,
    input  wire  lsq_pkg::lq_idx_t                       i_head,
    input  wire  [$clog2(DEQ_NUM+1)-1:0]                 i_commit_num,
    output logic [DEPTH-1:0]                             o_viol_vec,
    output lsq_pkg::rob_idx_t [DEPTH-1:0]                o_rob_idx
);

    localparam int AW = $clog2(DEPTH);

    lsq_pkg::lq_entry_t [DEPTH-1:0] ent;
    logic [DEQ_NUM-1:0][AW-1:0] ret_slot;
    logic [DEPTH-1:0] viol_next;
    logic [AW-1:0] iss_slot;
    logic [AW-1:0] wb_slot;
    mem_pkg::byte_mask_t st_mask;
    mem_pkg::dword_addr_t st_dw;

    assign iss_slot = i_ld_issue.lq_idx.slot[AW-1:0];
    assign wb_slot  = i_ld_wb.lq_idx.slot[AW-1:0];

    // slots freed this cycle, counted from the head
    always_comb begin
        for (int d = 0; d < DEQ_NUM; d++) begin
            ret_slot[d] = i_head.slot[AW-1:0] + AW'(d);
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ent <= '0;
        end else if (i_flush) begin
            for (int j = 0; j < DEPTH; j++) begin
                ent[j].valid <= 1'b0;
            end
        end else begin
            for (int d = 0; d < DEQ_NUM; d++) begin
                if (d < int'(i_commit_num)) begin
                    ent[ret_slot[d]].valid <= 1'b0;
                end
            end
            if (i_ld_issue.vld) begin
                ent[iss_slot].addr_vld <= 1'b1;
                ent[iss_slot].dw_addr  <= mem_pkg::dword_of(i_ld_issue.vaddr);
                ent[iss_slot].mask     <= mem_pkg::byte_mask_of(i_ld_issue.vaddr[2:0],
                                                                i_ld_issue.size);
            end
            if (i_ld_wb.vld) begin
                ent[wb_slot].finished <= 1'b1;
            end
            // new loads wait for the load pipe to supply the address
            // address and mask keep the old slot contents until then
            for (int k = 0; k < ENQ_NUM; k++) begin
                if (i_wr_en[k]) begin
                    ent[i_wr_slot[k][AW-1:0]].valid    <= 1'b1;
                    ent[i_wr_slot[k][AW-1:0]].addr_vld <= 1'b0;
                    ent[i_wr_slot[k][AW-1:0]].finished <= 1'b0;
                    ent[i_wr_slot[k][AW-1:0]].rob_idx  <= i_enq_rob_idx[k];
                    ent[i_wr_slot[k][AW-1:0]].sq_idx   <= i_enq_sq_idx[k];
                end
            end
        end
    end

    assign st_mask = mem_pkg::byte_mask_of(i_st_addr.vaddr[2:0], i_st_addr.size);
    assign st_dw   = mem_pkg::dword_of(i_st_addr.vaddr);

    // executed loads younger than the store that touch the same bytes
    always_comb begin
        for (int j = 0; j < DEPTH; j++) begin
            viol_next[j] = i_st_addr.vld && ent[j].valid && ent[j].addr_vld &&
                           lsq_pkg::sq_before(i_st_addr.sq_idx, ent[j].sq_idx) &&
                           (ent[j].dw_addr == st_dw) && |(ent[j].mask & st_mask);
            o_rob_idx[j] = ent[j].rob_idx;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_viol_vec <= '0;
        end else if (i_flush) begin
            o_viol_vec <= '0;
        end else begin
            o_viol_vec <= viol_next;
        end
    end

    a_issue_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_ld_issue.vld && !i_flush) |-> ent[iss_slot].valid)
        else $error("load issue to an empty queue slot");

    a_wb_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_ld_wb.vld && !i_flush) |-> ent[wb_slot].valid)
        else $error("load writeback to an empty queue slot");

    for (genvar d = 0; d < DEQ_NUM; d++) begin : g_ret_chk
        a_ret_finished: assert property (@(posedge clk) disable iff (!i_rst_n)
            (!i_flush && d < int'(i_commit_num)) |-> ent[ret_slot[d]].finished)
            else $error("retired load was never written back");
    end

endmodule

`default_nettype wire

//--- src/lq_oldest_select.sv
`timescale 1ns/1ps
`default_nettype none

module lq_oldest_select #(
    parameter int DEPTH = 8
) (
    input  wire                               clk,
    input  wire                               i_rst_n,
    input  wire                               i_flush,
    input  wire  [DEPTH-1:0]                  i_viol_vec,
    input  wire  lsq_pkg::rob_idx_t [DEPTH-1:0] i_rob_idx,
    input  wire  lsq_pkg::lq_idx_t            i_head,
    output logic                              o_violation,
    output lsq_pkg::rob_idx_t                 o_violation_rob_idx
);

    localparam int AW = $clog2(DEPTH);

    // head as it was when the violation vector was sampled
    logic [AW-1:0] head_q;
    logic [AW-1:0] pick;
    logic found;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            head_q <= '0;
        end else begin
            head_q <= i_head.slot[AW-1:0];
        end
    end

    // walk from the head, first hit is the oldest load
    always_comb begin
        logic [AW-1:0] idx;
        found = 1'b0;
        pick  = '0;
        for (int k = 0; k < DEPTH; k++) begin
            idx = head_q + AW'(k);
            if (!found && i_viol_vec[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    // the core is already redirecting on flush, drop the report
    assign o_violation = found && !i_flush;
    assign o_violation_rob_idx = i_rob_idx[pick];

endmodule

`default_nettype wire

//--- src/load_queue.sv
`timescale 1ns/1ps
`default_nettype none

module load_queue #(
    parameter int DEPTH   = 8,
    parameter int ENQ_NUM = 2,
    parameter int DEQ_NUM = 2
) (
    input  wire                                    clk,
    input  wire                                    i_rst_n,
    input  wire                                    i_flush,
    input  wire                                    i_enq_vld,
    input  wire  [ENQ_NUM-1:0]                     i_enq_req,
    input  wire  lsq_pkg::rob_idx_t [ENQ_NUM-1:0]  i_enq_rob_idx,
    input  wire  lsq_pkg::sq_idx_t [ENQ_NUM-1:0]   i_enq_sq_idx,
    input  wire  lsq_pkg::ld_issue_t               i_ld_issue,
    input  wire  lsq_pkg::ld_wb_t                  i_ld_wb,
    input  wire  lsq_pkg::st_addr_t                i_st_addr,
    input  wire  [$clog2(DEQ_NUM+1)-1:0]           i_commit_num,
    output logic                                   o_can_enq,
    output lsq_pkg::lq_idx_t [ENQ_NUM-1:0]         o_alloc_idx,
    output logic                                   o_violation,
    output lsq_pkg::rob_idx_t                      o_violation_rob_idx
);

    logic [ENQ_NUM-1:0] wr_en;
    logic [ENQ_NUM-1:0][lsq_pkg::LQ_SLOT_W-1:0] wr_slot;
    lsq_pkg::lq_idx_t head;
    logic [DEPTH-1:0] viol_vec;
    lsq_pkg::rob_idx_t [DEPTH-1:0] ent_rob_idx;

    lq_alloc #(.DEPTH(DEPTH), .ENQ_NUM(ENQ_NUM), .DEQ_NUM(DEQ_NUM)) u_alloc (
        .clk(clk), .i_rst_n(i_rst_n), .i_flush(i_flush),
        .i_enq_vld(i_enq_vld), .i_enq_req(i_enq_req), .i_commit_num(i_commit_num),
        .o_can_enq(o_can_enq), .o_alloc_idx(o_alloc_idx),
        .o_wr_en(wr_en), .o_wr_slot(wr_slot), .o_head(head)
    );

    lq_entries #(.DEPTH(DEPTH), .ENQ_NUM(ENQ_NUM), .DEQ_NUM(DEQ_NUM)) u_entries (
        .clk(clk), .i_rst_n(i_rst_n), .i_flush(i_flush),
        .i_wr_en(wr_en), .i_wr_slot(wr_slot),
        .i_enq_rob_idx(i_enq_rob_idx), .i_enq_sq_idx(i_enq_sq_idx),
        .i_ld_issue(i_ld_issue), .i_ld_wb(i_ld_wb), .i_st_addr(i_st_addr),
        .i_head(head), .i_commit_num(i_commit_num),
        .o_viol_vec(viol_vec), .o_rob_idx(ent_rob_idx)
    );

    lq_oldest_select #(.DEPTH(DEPTH)) u_select (
        .clk(clk), .i_rst_n(i_rst_n), .i_flush(i_flush),
        .i_viol_vec(viol_vec), .i_rob_idx(ent_rob_idx), .i_head(head),
        .o_violation(o_violation), .o_violation_rob_idx(o_violation_rob_idx)
    );

endmodule

`default_nettype wire

//--- testbench/tb_load_queue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_load_queue;

    localparam int DEPTH = 8;
    // rough sum of the directed tests, the random mix and the drains
    localparam int TEST_CYCLES = 400;
    localparam int MAX_CYCLES = 2 * TEST_CYCLES;

    logic clk;
    logic i_rst_n;
    logic flush;
    logic enq_vld;
    logic [1:0] enq_req;
    lsq_pkg::rob_idx_t [1:0] enq_rob;
    lsq_pkg::sq_idx_t [1:0] enq_sq;
    lsq_pkg::ld_issue_t ld_issue;
    lsq_pkg::ld_wb_t ld_wb;
    lsq_pkg::st_addr_t st_addr;
    logic [1:0] commit_num;
    logic can_enq;
    lsq_pkg::lq_idx_t [1:0] alloc_idx;
    logic viol;
    lsq_pkg::rob_idx_t viol_rob;

    // values for the next falling edge
    logic n_flush;
    logic n_enq_vld;
    logic [1:0] n_enq_req;
    logic [1:0] n_commit;
    lsq_pkg::rob_idx_t [1:0] n_rob;
    lsq_pkg::sq_idx_t [1:0] n_sq;
    lsq_pkg::ld_issue_t n_iss;
    lsq_pkg::ld_wb_t n_wb;
    lsq_pkg::st_addr_t n_st;

    // reference model
    int m_tail;
    int m_head;
    int m_count;
    bit m_valid[DEPTH];
    bit m_av[DEPTH];
    bit m_fin[DEPTH];
    lsq_pkg::rob_idx_t m_rob[DEPTH];
    lsq_pkg::sq_idx_t m_sq[DEPTH];
    logic [60:0] m_dw[DEPTH];
    logic [7:0] m_mask[DEPTH];
    logic pend;
    lsq_pkg::rob_idx_t pend_rob;

    logic exp_can_enq;
    logic exp_viol;
    logic [7:0] exp_alloc;
    lsq_pkg::rob_idx_t exp_rob;

    int seed;
    int errors;
    int err_start;
    int tests;
    int failed_tests;
    int cycles;
    string cur_test;

    load_queue #(.DEPTH(DEPTH), .ENQ_NUM(2), .DEQ_NUM(2)) i_dut (
        .clk(clk), .i_rst_n(i_rst_n), .i_flush(flush),
        .i_enq_vld(enq_vld), .i_enq_req(enq_req),
        .i_enq_rob_idx(enq_rob), .i_enq_sq_idx(enq_sq),
        .i_ld_issue(ld_issue), .i_ld_wb(ld_wb), .i_st_addr(st_addr),
        .i_commit_num(commit_num),
        .o_can_enq(can_enq), .o_alloc_idx(alloc_idx),
        .o_violation(viol), .o_violation_rob_idx(viol_rob)
    );

    always #10 clk = ~clk;

    task automatic mismatch(input string what, input int exp_v, input int act_v);
        errors++;
        $display("FAILED %s %s: expected %0h actual %0h", cur_test, what, exp_v, act_v);
    endtask

    a_can_enq: assert property (@(posedge clk) disable iff (!i_rst_n) can_enq == exp_can_enq)
        else mismatch("can_enq", exp_can_enq, $sampled(can_enq));
    a_alloc: assert property (@(posedge clk) disable iff (!i_rst_n) alloc_idx == exp_alloc)
        else mismatch("alloc_idx", exp_alloc, $sampled(alloc_idx));
    a_viol: assert property (@(posedge clk) disable iff (!i_rst_n) viol == exp_viol)
        else mismatch("violation", exp_viol, $sampled(viol));
    a_viol_rob: assert property (@(posedge clk) disable iff (!i_rst_n)
        exp_viol |-> viol_rob == exp_rob)
        else mismatch("violation rob", exp_rob, $sampled(viol_rob));

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles in test %s", cycles, cur_test);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // store a is older than load-side index b
    function automatic logic older(input lsq_pkg::sq_idx_t a, input lsq_pkg::sq_idx_t b);
        if (a.flag == b.flag) return a.slot < b.slot;
        return a.slot > b.slot;
    endfunction

    function automatic logic [7:0] mask_for(input logic [2:0] offs, input logic [1:0] size);
        logic [15:0] run;
        run = (16'h1 << (1 << size)) - 16'h1;
        return 8'(run << offs);
    endfunction

    function automatic lsq_pkg::sq_idx_t mk_sq(input logic flag, input int slot);
        lsq_pkg::sq_idx_t r;
        r.flag = flag;
        r.slot = 4'(slot);
        return r;
    endfunction

    task automatic clear_next();
        n_flush = 0;
        n_enq_vld = 0;
        n_enq_req = 0;
        n_commit = 0;
        n_rob = '0;
        n_sq = '0;
        n_iss = '0;
        n_wb = '0;
        n_st = '0;
    endtask

    // one cycle: drive, predict outputs, advance the model past the edge
    task automatic cycle();
        int free;
        int reqn;
        int off;
        int s;
        int j;
        logic hit;
        lsq_pkg::rob_idx_t hr;
        logic [7:0] smask;
        @(negedge clk);
        flush = n_flush;
        enq_vld = n_enq_vld;
        enq_req = n_enq_req;
        enq_rob = n_rob;
        enq_sq = n_sq;
        commit_num = n_commit;
        ld_issue = n_iss;
        ld_wb = n_wb;
        st_addr = n_st;
        reqn = n_enq_req[0] + n_enq_req[1];
        free = DEPTH - m_count;
        exp_can_enq = reqn <= free;
        off = 0;
        for (int k = 0; k < 2; k++) begin
            s = (m_tail + off) % 16;
            exp_alloc[k*4 +: 4] = 4'(s);
            off += n_enq_req[k];
        end
        exp_viol = pend && !n_flush;
        exp_rob = pend_rob;
        hit = 0;
        hr = '0;
        smask = mask_for(n_st.vaddr[2:0], n_st.size);
        for (int k = 0; k < DEPTH; k++) begin
            j = (m_head + k) % DEPTH;
            if (!hit && m_valid[j] && m_av[j] && older(n_st.sq_idx, m_sq[j]) &&
                m_dw[j] == n_st.vaddr[63:3] && (m_mask[j] & smask) != 0) begin
                hit = 1;
                hr = m_rob[j];
            end
        end
        pend = n_st.vld && hit && !n_flush;
        pend_rob = hr;
        if (n_flush) begin
            m_tail = 0;
            m_head = 0;
            m_count = 0;
            for (int k = 0; k < DEPTH; k++) m_valid[k] = 0;
        end else begin
            for (int d = 0; d < n_commit; d++) m_valid[(m_head + d) % DEPTH] = 0;
            m_head = (m_head + n_commit) % 16;
            if (n_iss.vld) begin
                s = n_iss.lq_idx.slot;
                m_av[s] = 1;
                m_dw[s] = n_iss.vaddr[63:3];
                m_mask[s] = mask_for(n_iss.vaddr[2:0], n_iss.size);
            end
            if (n_wb.vld) m_fin[n_wb.lq_idx.slot] = 1;
            if (n_enq_vld && exp_can_enq) begin
                for (int k = 0; k < 2; k++) begin
                    if (n_enq_req[k]) begin
                        s = exp_alloc[k*4 +: 3];
                        m_valid[s] = 1;
                        m_av[s] = 0;
                        m_fin[s] = 0;
                        m_rob[s] = n_rob[k];
                        m_sq[s] = n_sq[k];
                    end
                end
                m_tail = (m_tail + reqn) % 16;
                m_count += reqn;
            end
            m_count -= n_commit;
        end
        clear_next();
    endtask

    task automatic enq(input logic [1:0] req, input int rob0, input int rob1,
                       input lsq_pkg::sq_idx_t sq0);
        n_enq_vld = 1;
        n_enq_req = req;
        n_rob[0] = 6'(rob0);
        n_rob[1] = 6'(rob1);
        n_sq[0] = sq0;
        n_sq[1] = sq0;
        cycle();
    endtask

    task automatic issue(input int slot, input logic [63:0] addr, input logic [1:0] size);
        n_iss.vld = 1;
        n_iss.lq_idx.slot = 3'(slot);
        n_iss.vaddr = addr;
        n_iss.size = mem_pkg::mem_size_t'(size);
        cycle();
    endtask

    task automatic store(input lsq_pkg::sq_idx_t sq, input logic [63:0] addr,
                         input logic [1:0] size);
        n_st.vld = 1;
        n_st.sq_idx = sq;
        n_st.vaddr = addr;
        n_st.size = mem_pkg::mem_size_t'(size);
        cycle();
    endtask

    // write back and retire everything still queued
    task automatic drain();
        int j;
        while (m_count > 0) begin
            j = m_head % DEPTH;
            // a two-port request without valid shows the freed space
            n_enq_req = 2'b11;
            if (!m_fin[j]) begin
                n_wb.vld = 1;
                n_wb.lq_idx.slot = 3'(j);
                cycle();
            end else begin
                n_commit = (m_count >= 2 && m_fin[(j + 1) % DEPTH]) ? 2'd2 : 2'd1;
                cycle();
            end
        end
    endtask

    task automatic end_test();
        tests++;
        if (errors > err_start) failed_tests++;
        $display("test %s: %s (%0d errors)", cur_test,
                 (errors > err_start) ? "fail" : "ok", errors - err_start);
        err_start = errors;
    endtask

    task automatic random_mix(input int n);
        logic [31:0] r;
        int s;
        int c;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            n_enq_vld = r[0];
            n_enq_req = r[2:1];
            n_rob[0] = 6'($random(seed));
            n_rob[1] = 6'($random(seed));
            n_sq[0] = 5'($random(seed));
            n_sq[1] = 5'($random(seed));
            s = r[20:18];
            if (r[3] && m_valid[s]) begin
                n_iss.vld = 1;
                n_iss.lq_idx.slot = 3'(s);
                n_iss.vaddr = 64'h4000 + {r[17:16], r[10:8]};
                n_iss.size = mem_pkg::mem_size_t'(r[7:6]);
            end
            s = r[23:21];
            if (r[11] && m_valid[s] && m_av[s]) begin
                n_wb.vld = 1;
                n_wb.lq_idx.slot = 3'(s);
            end
            c = 0;
            if (m_count > 0 && m_fin[m_head % DEPTH]) c = 1;
            if (c == 1 && m_count > 1 && m_fin[(m_head + 1) % DEPTH]) c = 2;
            n_commit = 2'(r[13:12] % (c + 1));
            n_st.vld = r[14];
            n_st.sq_idx = 5'($random(seed));
            n_st.vaddr = 64'h4000 + {r[25:24], r[28:26]};
            n_st.size = mem_pkg::mem_size_t'(r[30:29]);
            cycle();
        end
    endtask

    initial begin
        int s;
        seed = 32'h87c3bca5;
        clk = 0;
        i_rst_n = 0;
        errors = 0;
        err_start = 0;
        tests = 0;
        failed_tests = 0;
        cycles = 0;
        m_tail = 0;
        m_head = 0;
        m_count = 0;
        pend = 0;
        pend_rob = '0;
        exp_can_enq = 1;
        exp_alloc = '0;
        exp_viol = 0;
        exp_rob = '0;
        for (int k = 0; k < DEPTH; k++) m_valid[k] = 0;
        cur_test = "reset";
        clear_next();
        flush = 0;
        enq_vld = 0;
        enq_req = 0;
        enq_rob = '0;
        enq_sq = '0;
        commit_num = 0;
        ld_issue = '0;
        ld_wb = '0;
        st_addr = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1;

        cur_test = "alloc_order";
        enq(2'b01, 1, 0, mk_sq(0, 0));
        enq(2'b11, 2, 3, mk_sq(0, 0));
        enq(2'b10, 0, 4, mk_sq(0, 0));
        drain();
        repeat (3) enq(2'b11, 5, 6, mk_sq(0, 0));
        drain();
        end_test();

        cur_test = "full_queue";
        repeat (3) enq(2'b11, 7, 8, mk_sq(0, 0));
        enq(2'b01, 9, 0, mk_sq(0, 0));
        enq(2'b11, 10, 11, mk_sq(0, 0));
        enq(2'b01, 12, 0, mk_sq(0, 0));
        enq(2'b01, 13, 0, mk_sq(0, 0));
        drain();
        end_test();

        cur_test = "violation";
        s = m_tail % DEPTH;
        enq(2'b01, 5, 0, mk_sq(0, 4));
        issue(s, 64'h1000, 2'd2);
        store(mk_sq(0, 2), 64'h1004, 2'd2);
        store(mk_sq(0, 2), 64'h1002, 2'd1);
        store(mk_sq(0, 2), 64'h1008, 2'd3);
        store(mk_sq(0, 6), 64'h1000, 2'd3);
        enq(2'b01, 7, 0, mk_sq(0, 4));
        store(mk_sq(0, 0), 64'h0, 2'd3);
        store(mk_sq(0, 0), 64'h1000, 2'd3);
        cycle();
        drain();
        end_test();

        cur_test = "oldest_select";
        while (m_head % DEPTH != 6) begin
            enq(2'b01, 1, 0, mk_sq(0, 0));
            drain();
        end
        for (int i = 0; i < 6; i++) enq(2'b01, 10 + i, 0, mk_sq(0, 5));
        for (int i = 5; i >= 0; i--) issue((6 + i) % DEPTH, 64'h2000, 2'd3);
        store(mk_sq(0, 1), 64'h2004, 2'd2);
        issue(6, 64'h3000, 2'd3);
        issue(7, 64'h3000, 2'd3);
        store(mk_sq(0, 1), 64'h2000, 2'd0);
        cycle();
        drain();
        end_test();

        cur_test = "random_mix";
        random_mix(300);
        end_test();

        cur_test = "flush";
        // drop whatever the random mix left queued
        n_flush = 1;
        cycle();
        enq(2'b11, 20, 21, mk_sq(0, 8));
        issue(0, 64'h5000, 2'd3);
        issue(1, 64'h5000, 2'd3);
        store(mk_sq(0, 1), 64'h5000, 2'd3);
        n_flush = 1;
        n_st.vld = 1;
        n_st.sq_idx = mk_sq(0, 1);
        n_st.vaddr = 64'h5000;
        n_st.size = mem_pkg::MEM_D;
        cycle();
        cycle();
        // slots 0 and 1 return without an address over the old one
        enq(2'b11, 22, 23, mk_sq(0, 8));
        store(mk_sq(0, 1), 64'h5000, 2'd3);
        cycle();
        drain();
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
src/mem_pkg.sv
src/lsq_pkg.sv
src/popcount.sv
src/lq_alloc.sv
src/lq_entries.sv
src/lq_oldest_select.sv
src/load_queue.sv
testbench/tb_load_queue.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the load queue testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_load_queue -f files.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "\*\*\* FAILED \*\*\*" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
